//--- source/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// CLK cycles per quarter of an SCL period
`define EE_SCL_QUARTER 4

// 2 KB array, 11-bit byte address
`define EE_ADDR_W 11

// upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

`endif

//--- source/eeprom_pkg.sv
package eeprom_pkg;

    // bus operations the sequencer hands to the bit engine
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_t;

    // one state per bus command, plus idle and the ack cycle
    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,    // repeated start before the read control byte
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } seq_state_t;

endpackage

//--- source/i2c_bit_engine.sv
`include "eeprom_defines.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::i2c_cmd_t cmd,
    input  logic [7:0]           tx_byte,
    input  logic                 master_nack,
    output logic                 engine_ready,
    output logic                 cmd_done,
    output logic [7:0]           rx_byte,
    output logic                 slave_ack,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    localparam int Q = `EE_SCL_QUARTER;
    localparam int QW = $clog2(Q + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(Q - 1);

    logic                 active;
    eeprom_pkg::i2c_cmd_t cmd_r;
    logic                 nack_r;
    logic [QW-1:0]        q_cnt;
    logic [1:0]           phase;
    logic [3:0]           bit_cnt;
    logic [3:0]           last_bit;
    logic [7:0]           shift;
    logic                 q_first;
    logic                 q_end;
    logic                 ack_bit;

    always_comb
    begin
        q_first = active && (q_cnt == '0);
        q_end   = active && (q_cnt == Q_LAST);
        ack_bit = (bit_cnt == 4'd8);    // ninth bit of a byte
        last_bit = (cmd_r == eeprom_pkg::CMD_WRITE || cmd_r == eeprom_pkg::CMD_READ) ?
                   4'd8 : 4'd0;
    end

    // phase actions happen on the first cycle of each quarter
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active       <= 1'b0;
            engine_ready <= 1'b1;
            cmd_done     <= 1'b0;
            cmd_r        <= eeprom_pkg::CMD_STOP;
            q_cnt        <= '0;
            phase        <= 2'd0;
            bit_cnt      <= 4'd0;
            scl          <= 1'b1;
            sda_oe       <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (cmd_valid)
            begin
                active       <= 1'b1;
                engine_ready <= 1'b0;
                cmd_r        <= cmd;
                q_cnt        <= '0;
                phase        <= 2'd0;
                bit_cnt      <= 4'd0;
            end
            else if (active)
            begin
                q_cnt <= q_end ? '0 : q_cnt + 1'b1;
                if (q_end)
                begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3)
                    begin
                        if (bit_cnt == last_bit)
                        begin
                            active   <= 1'b0;
                            cmd_done <= 1'b1;
                        end
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                if (q_first)
                begin
                    case (phase)
                        2'd0:
                        begin
                            scl <= 1'b0;    // sda setup
                            case (cmd_r)
                                eeprom_pkg::CMD_START: sda_oe <= 1'b0;
                                eeprom_pkg::CMD_STOP:  sda_oe <= 1'b1;
                                eeprom_pkg::CMD_WRITE: sda_oe <= ack_bit ? 1'b0 : ~shift[7];
                                default:               sda_oe <= ack_bit ? ~nack_r : 1'b0;
                            endcase
                        end
                        2'd1: scl <= 1'b1;
                        2'd2:
                        begin
                            if (cmd_r == eeprom_pkg::CMD_START)
                                sda_oe <= 1'b1;     // start edge
                            else if (cmd_r == eeprom_pkg::CMD_STOP)
                                sda_oe <= 1'b0;     // stop edge
                        end
                        default:
                        begin
                            if (cmd_r != eeprom_pkg::CMD_STOP)
                                scl <= 1'b0;    // bus idles with scl high after stop
                        end
                    endcase
                end
            end
            else if (cmd_done)
                engine_ready <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            shift  <= tx_byte;
            nack_r <= master_nack;
        end
        else if (q_first && phase == 2'd3 && cmd_r == eeprom_pkg::CMD_WRITE)
            shift <= {shift[6:0], 1'b0};
        if (q_first && phase == 2'd2 && !ack_bit && cmd_r == eeprom_pkg::CMD_READ)
            rx_byte <= {rx_byte[6:0], sda_in};  // msb first
        if (q_first && phase == 2'd2 && ack_bit && cmd_r == eeprom_pkg::CMD_WRITE)
            slave_ack <= ~sda_in;
    end

    a_cmd_when_ready: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> engine_ready);

    // only start and stop may move sda under a high scl
    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(cmd_r inside {eeprom_pkg::CMD_START, eeprom_pkg::CMD_STOP}))
        |-> $stable(sda_oe));

endmodule

//--- source/eeprom_sequencer.sv
`include "eeprom_defines.svh"

module eeprom_sequencer
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wr_data,
    output logic                  busy,
    output logic                  ack,
    output logic                  err,
    output logic [7:0]            rd_data,
    output logic                  cmd_valid,
    output eeprom_pkg::i2c_cmd_t  cmd,
    output logic [7:0]            tx_byte,
    output logic                  master_nack,
    input  logic                  engine_ready,
    input  logic                  cmd_done,
    input  logic [7:0]            rx_byte,
    input  logic                  slave_ack
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t after_done;
    logic                   issued;
    logic                   wr_op;
    logic [`EE_ADDR_W-1:0]  addr_r;
    logic [7:0]             data_r;
    logic                   issue_state;
    logic                   nack_seen;
    eeprom_pkg::i2c_cmd_t   next_cmd;
    logic [7:0]             next_tx;

    // command issued from each state
    always_comb
    begin
        issue_state = 1'b1;
        next_cmd    = eeprom_pkg::CMD_WRITE;
        next_tx     = 8'h00;
        case (state)
            eeprom_pkg::START,
            eeprom_pkg::RESTART: next_cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::CTRL_W:  next_tx = {`EE_DEV_CODE, addr_r[10:8], 1'b0};
            eeprom_pkg::ADDR:    next_tx = addr_r[7:0];
            eeprom_pkg::DATA_W:  next_tx = data_r;
            eeprom_pkg::CTRL_R:  next_tx = {`EE_DEV_CODE, addr_r[10:8], 1'b1};
            eeprom_pkg::DATA_R:  next_cmd = eeprom_pkg::CMD_READ;
            eeprom_pkg::STOP:    next_cmd = eeprom_pkg::CMD_STOP;
            default:             issue_state = 1'b0;
        endcase
    end

    // where to go once the engine reports the command done
    always_comb
    begin
        nack_seen  = 1'b0;
        after_done = eeprom_pkg::IDLE;
        case (state)
            eeprom_pkg::START:   after_done = eeprom_pkg::CTRL_W;
            eeprom_pkg::CTRL_W:
            begin
                nack_seen  = !slave_ack;    // device busy with its write cycle
                after_done = slave_ack ? eeprom_pkg::ADDR : eeprom_pkg::STOP;
            end
            eeprom_pkg::ADDR:
            begin
                nack_seen = !slave_ack;
                if (!slave_ack)
                    after_done = eeprom_pkg::STOP;
                else
                    after_done = wr_op ? eeprom_pkg::DATA_W : eeprom_pkg::RESTART;
            end
            eeprom_pkg::DATA_W:
            begin
                nack_seen  = !slave_ack;
                after_done = eeprom_pkg::STOP;
            end
            eeprom_pkg::RESTART: after_done = eeprom_pkg::CTRL_R;
            eeprom_pkg::CTRL_R:
            begin
                nack_seen  = !slave_ack;
                after_done = slave_ack ? eeprom_pkg::DATA_R : eeprom_pkg::STOP;
            end
            eeprom_pkg::DATA_R:  after_done = eeprom_pkg::STOP;
            eeprom_pkg::STOP:    after_done = eeprom_pkg::DONE;
            default:             after_done = eeprom_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            issued    <= 1'b0;
            wr_op     <= 1'b0;
            busy      <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
            cmd_valid <= 1'b0;
            cmd       <= eeprom_pkg::CMD_START;
        end
        else
        begin
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            if (issue_state && !issued && engine_ready)
            begin
                cmd_valid <= 1'b1;
                cmd       <= next_cmd;
                issued    <= 1'b1;
            end
            case (state)
                eeprom_pkg::IDLE:
                begin
                    if (wr || rd)
                    begin
                        wr_op <= wr;    // write wins
                        busy  <= 1'b1;
                        err   <= 1'b0;
                        state <= eeprom_pkg::START;
                    end
                end
                eeprom_pkg::DONE:
                begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= eeprom_pkg::IDLE;
                end
                default:
                begin
                    if (cmd_done)
                    begin
                        issued <= 1'b0;
                        state  <= after_done;
                        if (nack_seen)
                            err <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::IDLE && (wr || rd))
        begin
            addr_r <= addr;
            data_r <= wr_data;
        end
        if (issue_state && !issued && engine_ready)
        begin
            tx_byte     <= next_tx;
            master_nack <= (state == eeprom_pkg::DATA_R);   // single byte read
        end
        if (state == eeprom_pkg::DATA_R && cmd_done)
            rd_data <= rx_byte;
    end

    // engine back to ready by the time the host sees ack
    a_ack_engine_idle: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> engine_ready);

endmodule

//--- source/eeprom_ctrl_top.sv
`include "eeprom_defines.svh"

module eeprom_ctrl_top
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wr_data,
    output logic                  busy,
    output logic                  ack,
    output logic                  err,
    output logic [7:0]            rd_data,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);

    logic                 cmd_valid;
    eeprom_pkg::i2c_cmd_t cmd;
    logic [7:0]           tx_byte;
    logic                 master_nack;
    logic                 engine_ready;
    logic                 cmd_done;
    logic [7:0]           rx_byte;
    logic                 slave_ack;

    eeprom_sequencer u_seq
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wr_data      (wr_data),
        .busy         (busy),
        .ack          (ack),
        .err          (err),
        .rd_data      (rd_data),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .tx_byte      (tx_byte),
        .master_nack  (master_nack),
        .engine_ready (engine_ready),
        .cmd_done     (cmd_done),
        .rx_byte      (rx_byte),
        .slave_ack    (slave_ack)
    );

    i2c_bit_engine u_engine
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .tx_byte      (tx_byte),
        .master_nack  (master_nack),
        .engine_ready (engine_ready),
        .cmd_done     (cmd_done),
        .rx_byte      (rx_byte),
        .slave_ack    (slave_ack),
        .scl          (scl),
        .sda_oe       (sda_oe),
        .sda_in       (sda_in)
    );

endmodule

//--- dv/eeprom_model.sv
`include "eeprom_defines.svh"

module eeprom_model
#(
    parameter int TWR_CYCLES = 600
)
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]            mem [0:(1 << `EE_ADDR_W) - 1];
    logic                  scl_q;
    logic                  sda_q;
    logic                  listening;
    logic                  reading;
    logic                  got_rise;
    logic                  acked;
    logic                  rw;
    logic                  write_pending;
    logic                  ack_now;
    logic [3:0]            bit_cnt;
    logic [1:0]            byte_num;
    logic [7:0]            rx;
    logic [7:0]            wdata;
    logic [`EE_ADDR_W-1:0] ptr;
    int                    twr_cnt;

    initial
    begin
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
            mem[a] = a[7:0] ^ {a[10:8], 5'b10110};
    end

    // control byte is refused while the write cycle runs
    always_comb
    begin
        case (byte_num)
            2'd0:    ack_now = (rx[7:4] == `EE_DEV_CODE) && (twr_cnt == 0);
            2'd1,
            2'd2:    ack_now = 1'b1;
            default: ack_now = 1'b0;    // no page writes
        endcase
    end

    // bus watched at CLK rate, edges found from the previous sample
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            listening     <= 1'b0;
            reading       <= 1'b0;
            got_rise      <= 1'b0;
            write_pending <= 1'b0;
            sda_low       <= 1'b0;
            bit_cnt       <= 4'd0;
            byte_num      <= 2'd0;
            twr_cnt       <= 0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (twr_cnt != 0)
                twr_cnt <= twr_cnt - 1;
            if (scl_q && scl && sda_q && !sda)  // start or repeated start
            begin
                listening     <= 1'b1;
                reading       <= 1'b0;
                got_rise      <= 1'b0;
                write_pending <= 1'b0;
                sda_low       <= 1'b0;
                bit_cnt       <= 4'd0;
                byte_num      <= 2'd0;
            end
            else if (scl_q && scl && !sda_q && sda)    // stop
            begin
                listening <= 1'b0;
                reading   <= 1'b0;
                sda_low   <= 1'b0;
                if (write_pending)
                begin
                    mem[ptr]      <= wdata;
                    write_pending <= 1'b0;
                    twr_cnt       <= TWR_CYCLES;
                end
            end
            else if (listening && !scl_q && scl)
            begin
                got_rise <= 1'b1;
                if (!reading && bit_cnt < 4'd8)
                    rx <= {rx[6:0], sda};
                if (reading && bit_cnt == 4'd8)
                    listening <= 1'b0;  // single byte read, master nack
            end
            else if (listening && got_rise && scl_q && !scl)
            begin
                got_rise <= 1'b0;
                if (bit_cnt < 4'd7)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (reading)
                        sda_low <= !mem[ptr][6 - bit_cnt];
                end
                else if (bit_cnt == 4'd7)
                begin
                    bit_cnt <= 4'd8;
                    if (reading)
                        sda_low <= 1'b0;    // master owns the ack slot
                    else
                    begin
                        acked   <= ack_now;
                        sda_low <= ack_now;
                        if (byte_num == 2'd0)
                        begin
                            ptr[10:8] <= rx[3:1];   // block bits
                            rw        <= rx[0];
                        end
                        else if (byte_num == 2'd1)
                            ptr[7:0] <= rx;
                        else if (byte_num == 2'd2)
                        begin
                            wdata         <= rx;
                            write_pending <= 1'b1;
                        end
                    end
                end
                else
                begin
                    bit_cnt  <= 4'd0;
                    byte_num <= byte_num + 2'd1;
                    sda_low  <= 1'b0;
                    if (!acked)
                        listening <= 1'b0;
                    else if (byte_num == 2'd0 && rw)
                    begin
                        reading <= 1'b1;
                        sda_low <= !mem[ptr][7];
                    end
                end
            end
        end
    end

endmodule

//--- dv/tb_eeprom_ctrl.sv
`include "eeprom_defines.svh"

module tb_eeprom_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TWR_CYCLES  = 600;
    localparam int IDLE_CYCLES = TWR_CYCLES + 20;
    localparam int READ_BITS   = 39;    // start, 2 bytes, restart, 2 bytes, stop

    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            wr_data;
    logic                  busy;
    logic                  ack;
    logic                  err;
    logic [7:0]            rd_data;
    logic                  scl;
    logic                  sda_oe;
    logic                  model_sda_low;
    logic                  sda;

    logic [31:0]           op_q[$];
    logic [`EE_ADDR_W-1:0] addr_q[$];
    logic [7:0]            data_q[$];
    logic                  err_q[$];
    logic [7:0]            exp_q[$];
    logic [7:0]            sb_mem [0:(1 << `EE_ADDR_W) - 1];
    int                    seed = 37837;
    int                    cycles = 0;
    int                    cycle_limit = 0;

    assign sda = !(sda_oe || model_sda_low);    // wired-and with pull-up

    eeprom_ctrl_top uut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .busy    (busy),
        .ack     (ack),
        .err     (err),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_model #(.TWR_CYCLES(TWR_CYCLES)) slave
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic load_tests();
        int              fd;
        logic [8*96-1:0] line;
        logic [31:0]     op;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [31:0]     e;
        logic [31:0]     x;
        fd = $fopen("dv/eeprom_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open dv/eeprom_tests.txt for reading");
            $display("TEST RESULT: FAIL");
            $fatal(1, "no test file");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // comment lines never give five fields
                if ($sscanf(line, "%s %h %h %h %h", op, a, d, e, x) == 5)
                begin
                    op_q.push_back(op);
                    addr_q.push_back(a[`EE_ADDR_W-1:0]);
                    data_q.push_back(d[7:0]);
                    err_q.push_back(e[0]);
                    exp_q.push_back(x[7:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_request(input logic is_write, input logic [`EE_ADDR_W-1:0] a,
                                input logic [7:0] d);
        @(posedge CLK);
        wr      <= is_write;
        rd      <= !is_write;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack(output logic got_err, output logic [7:0] got_data);
        do
        begin
            @(posedge CLK);
        end
        while (ack !== 1'b1);
        got_err  = err;
        got_data = rd_data;
        assert (busy === 1'b0 && scl === 1'b1 && sda_oe === 1'b0)
        else
            stop_on_error($sformatf("bus not idle with ack, busy=%b scl=%b sda_oe=%b",
                                    busy, scl, sda_oe));
    endtask

    // also catches a late second ack
    task automatic hold_idle();
        repeat (IDLE_CYCLES)
        begin
            @(posedge CLK);
            assert (ack === 1'b0 && busy === 1'b0 && scl === 1'b1 && sda === 1'b1)
            else
                stop_on_error($sformatf("idle bus disturbed, ack=%b busy=%b scl=%b sda=%b",
                                        ack, busy, scl, sda));
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        assert (got === exp)
        else
            stop_on_error($sformatf("err is %b, expected %b", got, exp));
    endtask

    task automatic check_data(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got === exp)
        else
            stop_on_error($sformatf("read of %03h gave %02h, expected %02h", a, got, exp));
    endtask

    task automatic run_op(input int i);
        logic                  got_err;
        logic [7:0]            got_data;
        logic [`EE_ADDR_W-1:0] ra;
        logic [7:0]            rdat;
        case (op_q[i])
            "W":
            begin
                send_request(1'b1, addr_q[i], data_q[i]);
                wait_ack(got_err, got_data);
                check_err(got_err, err_q[i]);
                if (!got_err)
                    sb_mem[addr_q[i]] = data_q[i];
            end
            "R":
            begin
                send_request(1'b0, addr_q[i], 8'h00);
                wait_ack(got_err, got_data);
                check_err(got_err, err_q[i]);
                if (!err_q[i])
                    check_data(addr_q[i], got_data, exp_q[i]);
            end
            "WX":
            begin
                send_request(1'b1, addr_q[i], data_q[i]);
                do
                begin
                    @(posedge CLK);
                end
                while (busy !== 1'b1);
                send_request(1'b1, addr_q[i] ^ 11'h001, ~data_q[i]);   // lands while busy
                wait_ack(got_err, got_data);
                check_err(got_err, err_q[i]);
                sb_mem[addr_q[i]] = data_q[i];
                hold_idle();
            end
            "IDLE": hold_idle();
            "RAND":
            begin
                ra   = $random(seed);
                rdat = $random(seed);
                send_request(1'b1, ra, rdat);
                wait_ack(got_err, got_data);
                check_err(got_err, 1'b0);
                sb_mem[ra] = rdat;
                hold_idle();
                send_request(1'b0, ra, 8'h00);
                wait_ack(got_err, got_data);
                check_err(got_err, 1'b0);
                check_data(ra, got_data, sb_mem[ra]);
            end
            default: stop_on_error($sformatf("unknown operation %s in the test file", op_q[i]));
        endcase
    endtask

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        load_tests();
        cycle_limit = op_q.size() * (READ_BITS * 4 * `EE_SCL_QUARTER + TWR_CYCLES) * 2;
        repeat (2)
            @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        assert (busy === 1'b0 && scl === 1'b1 && sda_oe === 1'b0 && sda === 1'b1)
        else
            stop_on_error("bus not idle after reset");
        foreach (op_q[i])
            run_op(i);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctrl.sv

//--- dv/eeprom_tests.txt
# op addr wdata err rdata, all hex; op is W, R, WX (write plus ignored strobe), IDLE or RAND
# random pairs take addr and data from the seed and are checked against the scoreboard
W    0A5  11  0  00
IDLE 000  00  0  00
W    1A5  22  0  00
IDLE 000  00  0  00
W    7A5  77  0  00
IDLE 000  00  0  00
R    0A5  00  0  11
R    1A5  00  0  22
R    7A5  00  0  77
R    3A5  00  0  D3
W    2C0  5A  0  00
R    2C0  00  1  00
IDLE 000  00  0  00
R    2C0  00  0  5A
W    155  3C  0  00
IDLE 000  00  0  00
WX   154  A5  0  00
R    155  00  0  3C
R    154  00  0  A5
RAND 000  00  0  00
RAND 000  00  0  00
RAND 000  00  0  00
